// ==== hdl/rvc_defs.svh ====
// widths and reset values shared by the compressed-instruction expander
// include wherever a width or the configuration reset value is needed
`ifndef RVC_DEFS_SVH
`define RVC_DEFS_SVH

// ------------------------------
// instruction widths
// ------------------------------
`define RVC_ILEN 32
`define RVC_CLEN 16

// ------------------------------
// apb configuration port
// ------------------------------
`define RVC_APB_AW 4
`define RVC_APB_DW 32
`define RVC_CTRL_ADDR 0

// zcb disabled out of reset
`define RVC_ZCB_RESET 1'b0

`endif

// ==== hdl/rvc_isa_pkg.sv ====
// risc-v types and encodings used to expand rv32c words
`include "rvc_defs.svh"

package rvc_isa_pkg;

  typedef logic [`RVC_ILEN-1:0] rvc_word_t;
  typedef logic [`RVC_CLEN-1:0] rvc_half_t;
  typedef logic [6:0]           rvc_opcode_t;
  typedef logic [4:0]           rvc_reg_t;
  typedef logic [1:0]           rvc_quadrant_t;

  // ------------------------------
  // major opcodes of the 32-bit isa
  // ------------------------------
  localparam rvc_opcode_t OPCODE_OP     = 7'b0110011;
  localparam rvc_opcode_t OPCODE_OP_IMM = 7'b0010011;
  localparam rvc_opcode_t OPCODE_LOAD   = 7'b0000011;
  localparam rvc_opcode_t OPCODE_STORE  = 7'b0100011;
  localparam rvc_opcode_t OPCODE_LUI    = 7'b0110111;
  localparam rvc_opcode_t OPCODE_JAL    = 7'b1101111;
  localparam rvc_opcode_t OPCODE_JALR   = 7'b1100111;
  localparam rvc_opcode_t OPCODE_BRANCH = 7'b1100011;

  // quadrant field, 11 marks an uncompressed word
  localparam rvc_quadrant_t QUAD_C0 = 2'b00;
  localparam rvc_quadrant_t QUAD_C1 = 2'b01;
  localparam rvc_quadrant_t QUAD_C2 = 2'b10;
  localparam rvc_quadrant_t QUAD_32 = 2'b11;

  // ------------------------------
  // funct3 of each quadrant
  // ------------------------------
  localparam logic [2:0] C0_ADDI4SPN = 3'b000;
  localparam logic [2:0] C0_LW       = 3'b010;
  localparam logic [2:0] C0_ZCB      = 3'b100;
  localparam logic [2:0] C0_SW       = 3'b110;

  localparam logic [2:0] C1_ADDI     = 3'b000;
  localparam logic [2:0] C1_JAL      = 3'b001;
  localparam logic [2:0] C1_LI       = 3'b010;
  localparam logic [2:0] C1_LUI      = 3'b011;
  localparam logic [2:0] C1_MISC_ALU = 3'b100;
  localparam logic [2:0] C1_J        = 3'b101;
  localparam logic [2:0] C1_BEQZ     = 3'b110;
  localparam logic [2:0] C1_BNEZ     = 3'b111;

  localparam logic [2:0] C2_SLLI     = 3'b000;
  localparam logic [2:0] C2_LWSP     = 3'b010;
  localparam logic [2:0] C2_JR_MV    = 3'b100;
  localparam logic [2:0] C2_SWSP     = 3'b110;

  localparam rvc_reg_t  REG_SP      = 5'd2;
  localparam rvc_word_t EBREAK_WORD = 32'h0010_0073;

endpackage

// ==== hdl/rvc_bus_pkg.sv ====
// bundles that cross module boundaries: apb port, fetch input, expansion and result
`include "rvc_defs.svh"

package rvc_bus_pkg;

  // ------------------------------
  // apb configuration port
  // ------------------------------
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`RVC_APB_AW-1:0] paddr;
    logic [`RVC_APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`RVC_APB_DW-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  // ------------------------------
  // instruction data path
  // ------------------------------
  typedef struct packed {
    logic                  valid;
    rvc_isa_pkg::rvc_word_t word;
  } fetch_t;

  // per-quadrant expansion, combinational
  typedef struct packed {
    rvc_isa_pkg::rvc_word_t instr;
    logic                  illegal;
  } expand_t;

  typedef struct packed {
    logic                  valid;
    rvc_isa_pkg::rvc_word_t instr;
    logic                  illegal;
    logic                  compressed;
  } result_t;

endpackage

// ==== hdl/rvc_cfg_regs.sv ====
// apb slave with the control register; bit 0 turns the zcb expansions on
// zero wait states, unknown addresses answer with pslverr
`timescale 1ns/1ps
`include "rvc_defs.svh"

module rvc_cfg_regs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  rvc_bus_pkg::apb_req_t apb_req_i,
  output rvc_bus_pkg::apb_rsp_t apb_rsp_o,
  output logic                  zcb_en_o
);

  import rvc_bus_pkg::*;

  localparam logic [`RVC_APB_AW-1:0] CTRL_ADDR = `RVC_CTRL_ADDR;

  logic access;
  logic addr_hit;
  logic zcb_en_q;

  // second phase of a transfer
  assign access   = apb_req_i.psel && apb_req_i.penable;
  assign addr_hit = (apb_req_i.paddr == CTRL_ADDR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      zcb_en_q <= `RVC_ZCB_RESET;
    end else if (access && apb_req_i.pwrite && addr_hit) begin
      zcb_en_q <= apb_req_i.pwdata[0];
    end
  end

  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access && !addr_hit;
    apb_rsp_o.prdata  = '0;
    if (access && !apb_req_i.pwrite && addr_hit) begin
      apb_rsp_o.prdata = {{(`RVC_APB_DW-1){1'b0}}, zcb_en_q};
    end
  end

  assign zcb_en_o = zcb_en_q;

  // master must hold psel through the access phase
  a_penable_needs_psel : assert property (
    @(posedge clk_i) disable iff (reset_i) apb_req_i.penable |-> apb_req_i.psel
  ) else $error("apb penable high without psel");

endmodule

// ==== hdl/rvc_quadrant0.sv ====
// expands quadrant 0 words: addi4spn, lw, sw and the zcb byte/halfword accesses
`timescale 1ns/1ps

module rvc_quadrant0 (
  input  rvc_isa_pkg::rvc_half_t half_i,
  input  logic                   zcb_en_i,
  output rvc_bus_pkg::expand_t   exp_o
);

  import rvc_isa_pkg::*;
  import rvc_bus_pkg::*;

  rvc_reg_t rs1_c;
  rvc_reg_t rd_c;

  // 3-bit register fields select x8..x15
  assign rs1_c = {2'b01, half_i[9:7]};
  assign rd_c  = {2'b01, half_i[4:2]};

  always_comb begin
    exp_o.instr   = '0;
    exp_o.illegal = 1'b0;
    unique case (half_i[15:13])
      C0_ADDI4SPN: begin
        exp_o.instr   = {2'b0, half_i[10:7], half_i[12:11], half_i[5], half_i[6], 2'b00,
                         REG_SP, 3'b000, rd_c, OPCODE_OP_IMM};
        exp_o.illegal = (half_i[12:5] == 8'b0);
      end
      C0_LW: begin
        exp_o.instr = {5'b0, half_i[5], half_i[12:10], half_i[6], 2'b00,
                       rs1_c, 3'b010, rd_c, OPCODE_LOAD};
      end
      C0_SW: begin
        exp_o.instr = {5'b0, half_i[5], half_i[12], rd_c, rs1_c, 3'b010,
                       half_i[11:10], half_i[6], 2'b00, OPCODE_STORE};
      end
      C0_ZCB: begin
        exp_o.illegal = !zcb_en_i;
        unique case (half_i[12:10])
          3'b000: exp_o.instr = {10'b0, half_i[5], half_i[6], rs1_c, 3'b100, rd_c, OPCODE_LOAD};
          // bit 6 picks lh over lhu
          3'b001: exp_o.instr = {10'b0, half_i[5], 1'b0, rs1_c, half_i[6] ? 3'b001 : 3'b101,
                                 rd_c, OPCODE_LOAD};
          3'b010: exp_o.instr = {7'b0, rd_c, rs1_c, 3'b000, 3'b0, half_i[5], half_i[6],
                                 OPCODE_STORE};
          3'b011: exp_o.instr = {7'b0, rd_c, rs1_c, 3'b001, 3'b0, half_i[5], 1'b0,
                                 OPCODE_STORE};
          default: exp_o.illegal = 1'b1;
        endcase
      end
      // floating-point and reserved codes
      default: exp_o.illegal = 1'b1;
    endcase
  end

endmodule

// ==== hdl/rvc_quadrant1.sv ====
// expands quadrant 1 words: immediates, shifts, alu ops, jumps, branches, zcb alu ops
`timescale 1ns/1ps

module rvc_quadrant1 (
  input  rvc_isa_pkg::rvc_half_t half_i,
  input  logic                   zcb_en_i,
  output rvc_bus_pkg::expand_t   exp_o
);

  import rvc_isa_pkg::*;
  import rvc_bus_pkg::*;

  rvc_reg_t    rd;
  rvc_reg_t    rd_c;
  rvc_reg_t    rs2_c;
  logic [11:0] imm_sext;
  logic [19:0] jal_off;

  assign rd       = half_i[11:7];
  assign rd_c     = {2'b01, half_i[9:7]};
  assign rs2_c    = {2'b01, half_i[4:2]};
  assign imm_sext = {{7{half_i[12]}}, half_i[6:2]};

  // jal immediate field, shared by c.jal and c.j
  assign jal_off  = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7], half_i[2],
                     half_i[11], half_i[5:3], {9{half_i[12]}}};

  always_comb begin
    exp_o.instr   = '0;
    exp_o.illegal = 1'b0;
    unique case (half_i[15:13])
      C1_ADDI: exp_o.instr = {imm_sext, rd, 3'b000, rd, OPCODE_OP_IMM};
      C1_JAL:  exp_o.instr = {jal_off, 5'd1, OPCODE_JAL};
      C1_LI:   exp_o.instr = {imm_sext, 5'd0, 3'b000, rd, OPCODE_OP_IMM};
      C1_LUI: begin
        if (rd == REG_SP) begin
          // addi16sp, immediate in units of 16
          exp_o.instr = {{3{half_i[12]}}, half_i[4:3], half_i[5], half_i[2], half_i[6], 4'b0,
                         REG_SP, 3'b000, REG_SP, OPCODE_OP_IMM};
        end else begin
          exp_o.instr   = {{15{half_i[12]}}, half_i[6:2], rd, OPCODE_LUI};
          exp_o.illegal = ({half_i[12], half_i[6:2]} == 6'b0);
        end
      end
      C1_MISC_ALU: begin
        unique case (half_i[11:10])
          // srli / srai, bit 10 sets the arithmetic flag
          2'b00, 2'b01: exp_o.instr = {1'b0, half_i[10], 4'b0, half_i[12], half_i[6:2],
                                       rd_c, 3'b101, rd_c, OPCODE_OP_IMM};
          2'b10: exp_o.instr = {imm_sext, rd_c, 3'b111, rd_c, OPCODE_OP_IMM};
          2'b11: begin
            unique case ({half_i[12], half_i[6:5]})
              3'b000: exp_o.instr = {7'b0100000, rs2_c, rd_c, 3'b000, rd_c, OPCODE_OP};
              3'b001: exp_o.instr = {7'b0000000, rs2_c, rd_c, 3'b100, rd_c, OPCODE_OP};
              3'b010: exp_o.instr = {7'b0000000, rs2_c, rd_c, 3'b110, rd_c, OPCODE_OP};
              3'b011: exp_o.instr = {7'b0000000, rs2_c, rd_c, 3'b111, rd_c, OPCODE_OP};
              3'b110: begin
                exp_o.instr   = {7'b0000001, rs2_c, rd_c, 3'b000, rd_c, OPCODE_OP};
                exp_o.illegal = !zcb_en_i;
              end
              3'b111: begin
                // zcb unary group, only zext.b and not exist without bitmanip
                if (zcb_en_i && half_i[4:2] == 3'b000) begin
                  exp_o.instr = {12'h0ff, rd_c, 3'b111, rd_c, OPCODE_OP_IMM};
                end else if (zcb_en_i && half_i[4:2] == 3'b101) begin
                  exp_o.instr = {12'hfff, rd_c, 3'b100, rd_c, OPCODE_OP_IMM};
                end else begin
                  exp_o.illegal = 1'b1;
                end
              end
              default: exp_o.illegal = 1'b1;  // subw, addw, reserved
            endcase
          end
          default: exp_o.illegal = 1'b1;
        endcase
      end
      C1_J: exp_o.instr = {jal_off, 5'd0, OPCODE_JAL};
      // funct3 bit 0 comes from bit 13, beq or bne
      C1_BEQZ, C1_BNEZ: begin
        exp_o.instr = {{4{half_i[12]}}, half_i[6:5], half_i[2], 5'd0, rd_c, 2'b00, half_i[13],
                       half_i[11:10], half_i[4:3], half_i[12], OPCODE_BRANCH};
      end
      default: exp_o.illegal = 1'b1;
    endcase
  end

endmodule

// ==== hdl/rvc_quadrant2.sv ====
// expands quadrant 2 words: slli, lwsp, swsp and the mv/add/jr/jalr/ebreak group
`timescale 1ns/1ps

module rvc_quadrant2 (
  input  rvc_isa_pkg::rvc_half_t half_i,
  output rvc_bus_pkg::expand_t   exp_o
);

  import rvc_isa_pkg::*;
  import rvc_bus_pkg::*;

  rvc_reg_t rd;
  rvc_reg_t rs2;

  assign rd  = half_i[11:7];
  assign rs2 = half_i[6:2];

  always_comb begin
    exp_o.instr   = '0;
    exp_o.illegal = 1'b0;
    unique case (half_i[15:13])
      C2_SLLI: exp_o.instr = {6'b0, half_i[12], half_i[6:2], rd, 3'b001, rd, OPCODE_OP_IMM};
      C2_LWSP: begin
        exp_o.instr   = {4'b0, half_i[3:2], half_i[12], half_i[6:4], 2'b00,
                         REG_SP, 3'b010, rd, OPCODE_LOAD};
        exp_o.illegal = (rd == 5'd0);
      end
      C2_SWSP: begin
        exp_o.instr = {4'b0, half_i[8:7], half_i[12], rs2, REG_SP, 3'b010,
                       half_i[11:9], 2'b00, OPCODE_STORE};
      end
      C2_JR_MV: begin
        if (!half_i[12]) begin
          if (rs2 == 5'd0) begin
            // jr, rs1 of x0 is reserved
            exp_o.instr   = {12'b0, rd, 3'b000, 5'd0, OPCODE_JALR};
            exp_o.illegal = (rd == 5'd0);
          end else begin
            exp_o.instr = {7'b0, rs2, 5'd0, 3'b000, rd, OPCODE_OP};
          end
        end else if (rs2 != 5'd0) begin
          exp_o.instr = {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP};
        end else if (rd == 5'd0) begin
          exp_o.instr = EBREAK_WORD;
        end else begin
          // jalr links through x1
          exp_o.instr = {12'b0, rd, 3'b000, 5'd1, OPCODE_JALR};
        end
      end
      // fp stack accesses, zcmp and zcmt space
      default: exp_o.illegal = 1'b1;
    endcase
  end

endmodule

// ==== hdl/rvc_expander.sv ====
// registered rv32c expander with an apb switch for zcb
// one word in per cycle, result one cycle later, illegal words pass through as fetched
`timescale 1ns/1ps
`include "rvc_defs.svh"

module rvc_expander (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  rvc_bus_pkg::apb_req_t apb_req_i,
  output rvc_bus_pkg::apb_rsp_t apb_rsp_o,
  input  rvc_bus_pkg::fetch_t   fetch_i,
  output rvc_bus_pkg::result_t  result_o
);

  import rvc_isa_pkg::*;
  import rvc_bus_pkg::*;

  logic      zcb_en;
  rvc_half_t half;
  expand_t   exp_q0;
  expand_t   exp_q1;
  expand_t   exp_q2;
  expand_t   exp_sel;
  logic      compressed;
  result_t   result_d;
  result_t   result_q;

  assign half = fetch_i.word[`RVC_CLEN-1:0];

  rvc_cfg_regs u_cfg_regs (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .zcb_en_o  (zcb_en)
  );

  rvc_quadrant0 u_quadrant0 (.half_i(half), .zcb_en_i(zcb_en), .exp_o(exp_q0));
  rvc_quadrant1 u_quadrant1 (.half_i(half), .zcb_en_i(zcb_en), .exp_o(exp_q1));
  rvc_quadrant2 u_quadrant2 (.half_i(half), .exp_o(exp_q2));

  // ------------------------------
  // quadrant select
  // ------------------------------
  always_comb begin
    compressed = 1'b1;
    unique case (rvc_quadrant_t'(fetch_i.word[1:0]))
      QUAD_C0: exp_sel = exp_q0;
      QUAD_C1: exp_sel = exp_q1;
      QUAD_C2: exp_sel = exp_q2;
      QUAD_32: begin
        compressed = 1'b0;
        exp_sel    = '{instr: fetch_i.word, illegal: 1'b0};
      end
      default: exp_sel = exp_q0;
    endcase
  end

  always_comb begin
    result_d.valid      = fetch_i.valid;
    result_d.compressed = compressed;
    result_d.illegal    = exp_sel.illegal;
    result_d.instr      = exp_sel.illegal ? fetch_i.word : exp_sel.instr;
  end

  // only valid needs a reset, the rest is qualified by it
  always_ff @(posedge clk_i) begin
    result_q <= result_d;
    if (reset_i) begin
      result_q.valid <= 1'b0;
    end
  end

  assign result_o = result_q;

  // a full-width word can never be flagged by a quadrant decoder
  a_illegal_is_compressed : assert property (
    @(posedge clk_i) disable iff (reset_i)
      (result_o.valid && result_o.illegal) |-> result_o.compressed
  ) else $error("illegal flag set on an uncompressed word");

endmodule

// ==== testbench/tb_clk_gen.sv ====
// clock and reset source for the expander testbench
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge after the hold time
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== testbench/tb_rvc_expander.sv ====
// table-driven testbench for the rv32c expander
// drives fetch words and apb transfers and checks each result one cycle after it is driven
`timescale 1ns/1ps
`include "rvc_defs.svh"

module tb_rvc_expander;

  import rvc_isa_pkg::*;
  import rvc_bus_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int NUM_RANDOM   = 16;
  // read after reset, read of a bad address, zcb write, read back
  localparam int APB_CYCLES   = 4 * 3;
  localparam logic [`RVC_APB_AW-1:0] CTRL_ADDR = `RVC_CTRL_ADDR;
  localparam logic [`RVC_APB_AW-1:0] BAD_ADDR  = 4'h4;

  typedef struct {
    rvc_word_t word;
    logic      zcb;
    rvc_word_t exp_instr;
    logic      exp_illegal;
    logic      exp_compressed;
    string     name;
  } row_t;

  logic     clk;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  fetch_t   fetch;
  result_t  result;
  row_t     rows[$];
  logic     zcb_now;
  int       seed   = 69450;
  int       cycles = 0;
  int       limit  = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  rvc_expander dut0 (
    .clk_i     (clk),
    .reset_i   (reset),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .fetch_i   (fetch),
    .result_o  (result)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input rvc_word_t exp, input rvc_word_t act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // prdata only means something on an error-free read
  task automatic check_apb(input string name, input logic [`RVC_APB_DW-1:0] exp_data,
                           input logic exp_err, input apb_rsp_t act);
    if (act.pready !== 1'b1) begin
      stop_run($sformatf("ERROR %s pready: expected 1, actual %b", name, act.pready));
    end else if (act.pslverr !== exp_err) begin
      stop_run($sformatf("ERROR %s pslverr: expected %b, actual %b", name, exp_err,
                         act.pslverr));
    end else if (!exp_err && act.prdata !== exp_data) begin
      stop_run($sformatf("ERROR %s prdata: expected %h, actual %h", name, exp_data,
                         act.prdata));
    end
  endtask

  task automatic check_row(input row_t r);
    check_flag({r.name, " valid"}, 1'b1, result.valid);
    check_word(r.name, r.exp_instr, result.instr);
    check_flag({r.name, " illegal"}, r.exp_illegal, result.illegal);
    check_flag({r.name, " compressed"}, r.exp_compressed, result.compressed);
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  // setup and access cycles with the response sampled mid access
  task automatic apb_transfer(input logic write, input logic [`RVC_APB_AW-1:0] addr,
                              input logic [`RVC_APB_DW-1:0] data, output apb_rsp_t rsp);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rsp = apb_rsp;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic add_row(input rvc_word_t word, input logic zcb, input rvc_word_t exp_instr,
                         input logic exp_illegal, input logic exp_compressed,
                         input string name);
    rows.push_back(row_t'{word, zcb, exp_instr, exp_illegal, exp_compressed, name});
  endtask

  // an illegal compressed word comes back exactly as fetched
  task automatic add_illegal(input rvc_word_t word, input logic zcb, input string name);
    add_row(word, zcb, word, 1'b1, 1'b1, name);
  endtask

  task automatic build_table();
    add_row(32'h0000_0800, 1'b0, 32'h0101_0413, 1'b0, 1'b1, "c.addi4spn x8,16");
    add_row(32'hdead_4144, 1'b0, 32'h0045_2483, 1'b0, 1'b1, "c.lw x9,4(x10)");
    add_row(32'h0000_c504, 1'b0, 32'h0095_2423, 1'b0, 1'b1, "c.sw x9,8(x10)");
    add_row(32'h0000_52fd, 1'b0, 32'hfff0_0293, 1'b0, 1'b1, "c.li x5,-1");
    add_row(32'h0000_717d, 1'b0, 32'hff01_0113, 1'b0, 1'b1, "c.addi16sp -16");
    add_row(32'h0000_757d, 1'b0, 32'hffff_f537, 1'b0, 1'b1, "c.lui x10,0xfffff");
    add_row(32'h0000_c019, 1'b0, 32'h0004_0363, 1'b0, 1'b1, "c.beqz x8,+6");
    add_row(32'h0000_fcfd, 1'b0, 32'hfe04_9fe3, 1'b0, 1'b1, "c.bnez x9,-2");
    add_row(32'h0000_2021, 1'b0, 32'h0080_00ef, 1'b0, 1'b1, "c.jal +8");
    add_row(32'h0000_bff5, 1'b0, 32'hffdf_f06f, 1'b0, 1'b1, "c.j -4");
    add_row(32'h0000_40b2, 1'b0, 32'h00c1_2083, 1'b0, 1'b1, "c.lwsp x1,12");
    add_row(32'h0000_c606, 1'b0, 32'h0011_2623, 1'b0, 1'b1, "c.swsp x1,12");
    add_row(32'hbeef_852e, 1'b0, 32'h00b0_0533, 1'b0, 1'b1, "c.mv x10,x11");
    add_row(32'h0000_952e, 1'b0, 32'h00b5_0533, 1'b0, 1'b1, "c.add x10,x11");
    add_row(32'h0000_8082, 1'b0, 32'h0000_8067, 1'b0, 1'b1, "c.jr x1");
    add_row(32'h0000_9282, 1'b0, 32'h0002_80e7, 1'b0, 1'b1, "c.jalr x5");
    add_row(32'h0000_9002, 1'b0, 32'h0010_0073, 1'b0, 1'b1, "c.ebreak");
    add_illegal(32'habcd_0010, 1'b0, "c.addi4spn zero imm");
    add_illegal(32'h1234_4002, 1'b0, "c.lwsp x0");
    add_illegal(32'h0000_8002, 1'b0, "c.jr x0");
    add_illegal(32'h0000_9c05, 1'b0, "c.subw");
    add_illegal(32'h5555_6000, 1'b0, "c.flw");
    add_illegal(32'h0000_8144, 1'b0, "c.lbu zcb off");
    add_illegal(32'h0000_9c45, 1'b0, "c.mul zcb off");
    add_illegal(32'h0000_9c75, 1'b0, "c.not zcb off");
    add_row(32'h0000_8144, 1'b1, 32'h0015_4483, 1'b0, 1'b1, "c.lbu x9,1(x10)");
    add_row(32'h0000_9c45, 1'b1, 32'h0294_0433, 1'b0, 1'b1, "c.mul x8,x9");
    add_row(32'h0000_9c75, 1'b1, 32'hfff4_4413, 1'b0, 1'b1, "c.not x8");
    add_row(32'h0000_9c61, 1'b1, 32'h0ff4_7413, 1'b0, 1'b1, "c.zext.b x8");
  endtask

  // one word per cycle with each result checked on the following cycle
  task automatic apply_rows(input int first, input int last);
    for (int i = first; i <= last + 1; i++) begin
      @(posedge clk);
      if (i <= last) begin
        fetch <= '{valid: 1'b1, word: rows[i].word};
      end else begin
        fetch <= '0;
      end
      @(negedge clk);
      if (i > first) begin
        check_row(rows[i - 1]);
      end
    end
  endtask

  initial begin
    apb_rsp_t  rsp;
    rvc_word_t rnd;
    int        n_table;
    int        first;
    int        last;
    // valid stays high through reset and the result must still read invalid
    fetch   = '{valid: 1'b1, word: '0};
    apb_req = '0;
    zcb_now = `RVC_ZCB_RESET;
    build_table();
    n_table = rows.size();
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd      = $random(seed);
      rnd[1:0] = 2'b11;
      add_row(rnd, 1'b1, rnd, 1'b0, 1'b0, $sformatf("uncompressed %0d", i));
    end
    limit = 2 * (n_table + NUM_RANDOM + APB_CYCLES + RESET_CYCLES);

    wait (reset === 1'b0);
    fetch <= '0;
    @(negedge clk);
    check_flag("valid after reset", 1'b0, result.valid);
    apb_transfer(1'b0, CTRL_ADDR, '0, rsp);
    check_apb("ctrl after reset", {{(`RVC_APB_DW-1){1'b0}}, `RVC_ZCB_RESET}, 1'b0, rsp);
    apb_transfer(1'b0, BAD_ADDR, '0, rsp);
    check_apb("bad address", '0, 1'b1, rsp);

    // runs of rows that share a zcb setting
    first = 0;
    while (first < rows.size()) begin
      last = first;
      while (last + 1 < rows.size() && rows[last + 1].zcb == rows[first].zcb) begin
        last++;
      end
      if (rows[first].zcb != zcb_now) begin
        apb_transfer(1'b1, CTRL_ADDR, {{(`RVC_APB_DW-1){1'b0}}, rows[first].zcb}, rsp);
        check_flag("zcb write pready", 1'b1, rsp.pready);
        check_flag("zcb write pslverr", 1'b0, rsp.pslverr);
        apb_transfer(1'b0, CTRL_ADDR, '0, rsp);
        check_apb("zcb read back", {{(`RVC_APB_DW-1){1'b0}}, rows[first].zcb}, 1'b0, rsp);
        zcb_now = rows[first].zcb;
      end
      apply_rows(first, last);
      first = last + 1;
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== rvc_expander.f ====
+incdir+hdl
hdl/rvc_isa_pkg.sv
hdl/rvc_bus_pkg.sv
hdl/rvc_cfg_regs.sv
hdl/rvc_quadrant0.sv
hdl/rvc_quadrant1.sv
hdl/rvc_quadrant2.sv
hdl/rvc_expander.sv
testbench/tb_clk_gen.sv
testbench/tb_rvc_expander.sv

// ==== Makefile ====
# Verilator build for the rv32c expander testbench
VERILATOR ?= verilator
TOP       ?= tb_rvc_expander
FILELIST  ?= rvc_expander.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
